//--- sources.f
rtl/backend_pkg.sv
rtl/issue_dispatch.sv
rtl/exec_lane.sv
rtl/reorder_commit.sv
rtl/int_backend.sv
test/clock_gen.sv
test/int_backend_chk.sv
test/int_backend_tb.sv

//--- test/int_backend_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer back end testbench
// Directed, latency and random ops against a reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module int_backend_tb;

  import backend_pkg::*;

  localparam int          DRIVE_DELAY  = 10;
  localparam int          RESET_CYCLES = 5;
  localparam int          IDLE_CYCLES  = 10;
  localparam int          NUM_OPCODES  = 9;
  localparam int          CORNER_PAIRS = 4;
  localparam int          CORNER_OPS   = NUM_OPCODES * CORNER_PAIRS;
  localparam int          RANDOM_OPS   = 200;
  localparam int          TOTAL_OPS    = CORNER_OPS + 2 + 4 + RANDOM_OPS;
  localparam int          CYCLE_LIMIT  = TOTAL_OPS * (MUL_STEPS + 4) + 50;
  localparam int          ALU_LATENCY  = 3;
  localparam int          MUL_LATENCY  = MUL_STEPS + 2;
  localparam logic [31:0] RANDOM_SEED  = 32'h296d_d587;

  logic     clock;
  logic     reset;
  logic     issue_valid;
  uop_t     issue_uop;
  logic     retire_valid;
  retire_t  retire_data;

  // Expected retirements in program order
  retire_t  expect_q[$];

  int issued_count  = 0;
  int retired_count = 0;
  int cycle_count   = 0;
  int issue_stamp   = 0;
  int retire_stamp  = 0;

  clock_gen clock_gen_inst (
    .clock (clock)
  );

  int_backend int_backend_inst (
    .clock        (clock),
    .reset        (reset),
    .issue_valid  (issue_valid),
    .issue_uop    (issue_uop),
    .retire_valid (retire_valid),
    .retire_data  (retire_data)
  );

  // Expected retirement of one micro-op
  function automatic retire_t reference_retire(input uop_t u);
    retire_t r;
    r.rd = u.rd;
    case (u.op)
      op_add:  r.data = u.src_a + u.src_b;
      op_sub:  r.data = u.src_a - u.src_b;
      op_and:  r.data = u.src_a & u.src_b;
      op_or:   r.data = u.src_a | u.src_b;
      op_xor:  r.data = u.src_a ^ u.src_b;
      op_sll:  r.data = u.src_a << u.src_b[4:0];
      op_srl:  r.data = u.src_a >> u.src_b[4:0];
      op_sltu: r.data = (u.src_a < u.src_b) ? 32'd1 : 32'd0;
      op_mul:  r.data = u.src_a * u.src_b;
      default: r.data = 'x;
    endcase
    return r;
  endfunction

  function automatic int checker_errors();
    return int_backend_inst.dispatch_inst.dispatch_chk_inst.fail_count +
           int_backend_inst.commit_inst.commit_chk_inst.fail_count;
  endfunction

  task automatic check_retire(input retire_t actual, input retire_t expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: retired rd %0d data %h, expected rd %0d data %h",
               $time, actual.rd, actual.data, expected.rd, expected.data);
      $display("TB FAILED");
      $fatal(1, "retirement mismatch");
    end
  endtask

  task automatic check_idle(input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: retire_valid %b, expected %b", $time, actual, expected);
      $display("TB FAILED");
      $fatal(1, "retire strobe mismatch");
    end
  endtask

  task automatic check_latency(input int actual, input int expected);
    if (actual != expected) begin
      $display("CHECK FAILED at %0t: latency %0d cycles, expected %0d", $time, actual, expected);
      $display("TB FAILED");
      $fatal(1, "latency mismatch");
    end
  endtask

  // Drive one op, waiting first while the buffer is full
  task automatic issue_op(
    input alu_op_e           op,
    input logic [REG_W-1:0]  rd,
    input logic [DATA_W-1:0] a,
    input logic [DATA_W-1:0] b
  );
    uop_t u;
    u.op    = op;
    u.rd    = rd;
    u.src_a = a;
    u.src_b = b;
    u.tag   = '0;
    while (issued_count - retired_count >= ROB_DEPTH) begin
      @(posedge clock);
      #DRIVE_DELAY;
    end
    issue_valid = 1'b1;
    issue_uop   = u;
    expect_q.push_back(reference_retire(u));
    issued_count++;
    @(posedge clock);
    issue_stamp = cycle_count;
    #DRIVE_DELAY;
    issue_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (issued_count != retired_count) begin
      @(posedge clock);
      #DRIVE_DELAY;
    end
  endtask

  task automatic expect_idle(input int cycles);
    repeat (cycles) begin
      @(posedge clock);
      check_idle(retire_valid, 1'b0);
    end
    #DRIVE_DELAY;
  endtask

  task automatic run_corner_ops();
    logic [DATA_W-1:0] a_list[CORNER_PAIRS];
    logic [DATA_W-1:0] b_list[CORNER_PAIRS];
    a_list = '{32'h0000_0000, 32'hffff_ffff, 32'hffff_ffff, 32'h8000_0001};
    b_list = '{32'h0000_0000, 32'hffff_ffff, 32'd31, 32'h0000_0003};
    for (int op_idx = 0; op_idx < NUM_OPCODES; op_idx++) begin
      for (int k = 0; k < CORNER_PAIRS; k++) begin
        issue_op(alu_op_e'(op_idx), REG_W'(op_idx * CORNER_PAIRS + k), a_list[k], b_list[k]);
      end
    end
  endtask

  task automatic run_random_ops();
    int gap;
    for (int n = 0; n < RANDOM_OPS; n++) begin
      gap = $urandom_range(0, 3);
      repeat (gap) begin
        @(posedge clock);
        #DRIVE_DELAY;
      end
      issue_op(alu_op_e'($urandom_range(0, NUM_OPCODES - 1)), REG_W'($urandom),
               $urandom, $urandom);
    end
  endtask

  // Cycle counter, timeout and checker watch
  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles with ops still outstanding", cycle_count);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end else if (checker_errors() != 0) begin
      $display("A bound assertion on the back end failed");
      $display("TB FAILED");
      $fatal(1, "assertion failure");
    end
  end

  // Compare every retirement with the oldest expected result
  always @(posedge clock) begin
    if (!reset && retire_valid) begin
      if (expect_q.size() == 0) begin
        $display("An op retired at %0t with no op outstanding", $time);
        $display("TB FAILED");
        $fatal(1, "unexpected retirement");
      end else begin
        check_retire(retire_data, expect_q.pop_front());
        retired_count++;
        retire_stamp = cycle_count;
      end
    end
  end

  initial begin
    reset       = 1'b1;
    issue_valid = 1'b0;
    issue_uop   = '0;
    void'($urandom(RANDOM_SEED));
    repeat (RESET_CYCLES) @(posedge clock);
    #DRIVE_DELAY;
    reset = 1'b0;

    // Quiet after reset
    expect_idle(IDLE_CYCLES);

    run_corner_ops();
    wait_drain();

    // Strobe is seen at the edge that ends its cycle, hence the minus one
    issue_op(op_add, 5'd7, 32'd100, 32'd23);
    wait_drain();
    check_latency(retire_stamp - issue_stamp - 1, ALU_LATENCY);
    issue_op(op_mul, 5'd9, 32'h0001_2345, 32'h0000_6789);
    wait_drain();
    check_latency(retire_stamp - issue_stamp - 1, MUL_LATENCY);

    // Slow multiply ahead of fast adds
    issue_op(op_mul, 5'd1, 32'hdead_beef, 32'h1234_5679);
    issue_op(op_add, 5'd2, 32'd5, 32'd6);
    issue_op(op_add, 5'd3, 32'hffff_ffff, 32'd1);
    issue_op(op_add, 5'd4, 32'h7fff_ffff, 32'h7fff_ffff);
    wait_drain();

    run_random_ops();
    wait_drain();
    expect_idle(IDLE_CYCLES);

    if (expect_q.size() == 0 && checker_errors() == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("Expected results left over or a bound assertion failed");
      $display("TB FAILED");
      $fatal(1, "end of run check");
    end
  end

endmodule

//--- test/int_backend_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Back end protocol checker
// Lane allocation and retire reset invariants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module int_backend_chk (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                issue_valid,
  input  logic [backend_pkg::LANE_COUNT-1:0]  lane_busy,
  input  logic [backend_pkg::LANE_COUNT-1:0]  lane_start,
  input  logic                                retire_valid
);

  // Failed assertion count, polled by the testbench
  int fail_count = 0;

  // An issue needs an idle lane
  issue_lane_free: assert property (
    @(posedge clock) disable iff (reset) issue_valid |-> !(&lane_busy)
  ) else begin
    fail_count++;
    $error("issue arrived while every lane was busy");
  end

  // At most one lane starts per cycle
  start_onehot: assert property (
    @(posedge clock) disable iff (reset) $onehot0(lane_start)
  ) else begin
    fail_count++;
    $error("more than one lane started in one cycle");
  end

  // Retire strobe cleared by reset
  retire_quiet_in_reset: assert property (
    @(posedge clock) reset |=> !retire_valid
  ) else begin
    fail_count++;
    $error("retire strobe high during reset");
  end

endmodule

bind issue_dispatch int_backend_chk dispatch_chk_inst (
  .clock        (clock),
  .reset        (reset),
  .issue_valid  (issue_valid),
  .lane_busy    (lane_busy),
  .lane_start   (lane_start),
  .retire_valid (1'b0)
);

bind reorder_commit int_backend_chk commit_chk_inst (
  .clock        (clock),
  .reset        (reset),
  .issue_valid  (1'b0),
  .lane_busy    ('0),
  .lane_start   ('0),
  .retire_valid (retire_valid)
);

//--- test/clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock source, 100 ns period
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module clock_gen (
  output logic clock
);

  localparam int HALF_PERIOD = 50;

  initial begin
    clock = 1'b0;
  end

  always #HALF_PERIOD clock = ~clock;

endmodule

//--- rtl/int_backend.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer back end top level
// Dispatcher, execution lanes and commit buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module int_backend (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  issue_valid,
  input  backend_pkg::uop_t     issue_uop,
  output logic                  retire_valid,
  output backend_pkg::retire_t  retire_data
);

  import backend_pkg::*;

  // Dispatcher to lanes
  logic [LANE_COUNT-1:0]     lane_start;
  logic [LANE_COUNT-1:0]     lane_busy;
  uop_t                      lane_uop;

  // Lanes to commit
  logic [LANE_COUNT-1:0]     lane_done;
  result_t [LANE_COUNT-1:0]  lane_result;

  issue_dispatch dispatch_inst (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue_uop   (issue_uop),
    .lane_busy   (lane_busy),
    .lane_start  (lane_start),
    .lane_uop    (lane_uop)
  );

  // All lanes see the same tagged op, the start bit selects one
  for (genvar i = 0; i < LANE_COUNT; i++) begin : lane_gen
    exec_lane lane_inst (
      .clock  (clock),
      .reset  (reset),
      .start  (lane_start[i]),
      .uop    (lane_uop),
      .busy   (lane_busy[i]),
      .done   (lane_done[i]),
      .result (lane_result[i])
    );
  end

  reorder_commit commit_inst (
    .clock        (clock),
    .reset        (reset),
    .lane_done    (lane_done),
    .lane_result  (lane_result),
    .retire_valid (retire_valid),
    .retire_data  (retire_data)
  );

endmodule

//--- rtl/reorder_commit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reorder and commit buffer
// Collects lane results by tag, retires them in order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module reorder_commit (
  input  logic                                                    clock,
  input  logic                                                    reset,
  input  logic [backend_pkg::LANE_COUNT-1:0]                      lane_done,
  input  backend_pkg::result_t [backend_pkg::LANE_COUNT-1:0]      lane_result,
  output logic                                                    retire_valid,
  output backend_pkg::retire_t                                    retire_data
);

  import backend_pkg::*;

  // Entry storage, indexed by tag
  retire_t               entry_q [ROB_DEPTH];
  logic [ROB_DEPTH-1:0]  valid_q;

  // Oldest op still in flight
  logic [TAG_W-1:0]      head_q;

  logic                  head_ready;

  assign head_ready = valid_q[head_q];

  // Valid bits, head pointer and retire strobe
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q      <= '0;
      head_q       <= '0;
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= head_ready;
      if (head_ready) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= head_q + 1'b1;
      end
      // A waiting head is never valid, so a write never meets the clear
      for (int i = 0; i < LANE_COUNT; i++) begin
        if (lane_done[i]) begin
          valid_q[lane_result[i].tag] <= 1'b1;
        end
      end
    end
  end

  // Result payload, several lanes may land in one cycle
  always_ff @(posedge clock) begin
    for (int i = 0; i < LANE_COUNT; i++) begin
      if (lane_done[i]) begin
        entry_q[lane_result[i].tag].rd   <= lane_result[i].rd;
        entry_q[lane_result[i].tag].data <= lane_result[i].data;
      end
    end
  end

  // Retire register
  always_ff @(posedge clock) begin
    if (head_ready) begin
      retire_data <= entry_q[head_q];
    end
  end

endmodule

//--- rtl/exec_lane.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execution lane
// One-step ALU ops and a shift-add multiplier
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module exec_lane (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  start,
  input  backend_pkg::uop_t     uop,
  output logic                  busy,
  output logic                  done,
  output backend_pkg::result_t  result
);

  import backend_pkg::*;

  // Captured op
  alu_op_e            op_q;

  // Operand registers, reused as multiplicand and multiplier
  logic [DATA_W-1:0]  opa_q;
  logic [DATA_W-1:0]  opb_q;

  // Product accumulator and remaining multiply steps
  logic [DATA_W-1:0]  acc_q;
  logic [STEP_W-1:0]  step_q;

  logic [DATA_W-1:0]  partial;
  logic               finish;

  function automatic logic [DATA_W-1:0] alu_calc(
    input alu_op_e           op,
    input logic [DATA_W-1:0] a,
    input logic [DATA_W-1:0] b
  );
    case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_and:  return a & b;
      op_or:   return a | b;
      op_xor:  return a ^ b;
      op_sll:  return a << b[4:0];
      op_srl:  return a >> b[4:0];
      op_sltu: return DATA_W'(a < b);
      default: return '0;
    endcase
  endfunction

  // Partial products for the low multiplier bits of this step
  always_comb begin
    partial = '0;
    for (int k = 0; k < MUL_BITS_PER_STEP; k++) begin
      if (opb_q[k]) begin
        partial = partial + (opa_q << k);
      end
    end
  end

  // Last busy cycle, ALU ops take one, multiply takes MUL_STEPS
  assign finish = busy && ((op_q != op_mul) || (step_q == '0));

  always_ff @(posedge clock) begin
    if (reset) begin
      busy   <= 1'b0;
      done   <= 1'b0;
      step_q <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy   <= 1'b1;
        step_q <= (uop.op == op_mul) ? STEP_W'(MUL_STEPS - 1) : '0;
      end else if (finish) begin
        busy <= 1'b0;
        done <= 1'b1;
      end else if (busy) begin
        step_q <= step_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      op_q       <= uop.op;
      opa_q      <= uop.src_a;
      opb_q      <= uop.src_b;
      acc_q      <= '0;
      // Tag and rd ride through with the op
      result.tag <= uop.tag;
      result.rd  <= uop.rd;
    end else if (busy) begin
      if (op_q == op_mul) begin
        acc_q <= acc_q + partial;
        opa_q <= opa_q << MUL_BITS_PER_STEP;
        opb_q <= opb_q >> MUL_BITS_PER_STEP;
      end
      if (finish) begin
        result.data <= (op_q == op_mul) ? acc_q + partial : alu_calc(op_q, opa_q, opb_q);
      end
    end
  end

endmodule

//--- rtl/issue_dispatch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue dispatcher
// Tags each micro-op and steers it to the lowest free lane
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module issue_dispatch (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                issue_valid,
  input  backend_pkg::uop_t                   issue_uop,
  input  logic [backend_pkg::LANE_COUNT-1:0]  lane_busy,
  output logic [backend_pkg::LANE_COUNT-1:0]  lane_start,
  output backend_pkg::uop_t                   lane_uop
);

  import backend_pkg::*;

  // Next reorder tag in program order
  logic [TAG_W-1:0] tag_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      tag_q <= '0;
    end else if (issue_valid) begin
      // Wraps with the buffer index
      tag_q <= tag_q + 1'b1;
    end
  end

  // Forward the op with its tag filled in
  always_comb begin
    lane_uop     = issue_uop;
    lane_uop.tag = tag_q;
  end

  // Priority encoder, lowest idle lane wins
  always_comb begin : pick_lane
    logic found;
    lane_start = '0;
    found      = 1'b0;
    for (int i = 0; i < LANE_COUNT; i++) begin
      if (issue_valid && !lane_busy[i] && !found) begin
        lane_start[i] = 1'b1;
        found         = 1'b1;
      end
    end
  end

endmodule

//--- rtl/backend_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer back end shared definitions
// Widths, counts, opcodes and the micro-op and result records
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package backend_pkg;

  // Datapath and register index widths
  localparam int DATA_W = 32;
  localparam int REG_W  = 5;

  // Execution resources
  localparam int LANE_COUNT = 4;

  // Reorder buffer size, also the in-flight limit
  localparam int ROB_DEPTH = 4;
  localparam int TAG_W     = $clog2(ROB_DEPTH);

  // Iterative multiplier
  localparam int MUL_BITS_PER_STEP = 2;
  localparam int MUL_STEPS         = DATA_W / MUL_BITS_PER_STEP;
  localparam int STEP_W            = $clog2(MUL_STEPS);

  // Integer opcodes
  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_sll  = 4'd5,
    op_srl  = 4'd6,
    op_sltu = 4'd7,
    op_mul  = 4'd8
  } alu_op_e;

  // Issued micro-op, operands travel as values
  typedef struct packed {
    alu_op_e             op;
    logic [REG_W-1:0]    rd;
    logic [DATA_W-1:0]   src_a;
    logic [DATA_W-1:0]   src_b;
    logic [TAG_W-1:0]    tag;
  } uop_t;

  // Lane completion, written into the reorder buffer by tag
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [REG_W-1:0]    rd;
    logic [DATA_W-1:0]   data;
  } result_t;

  // In-order retirement
  typedef struct packed {
    logic [REG_W-1:0]    rd;
    logic [DATA_W-1:0]   data;
  } retire_t;

endpackage
